/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dispatch
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* allocator.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defs.svh"

module allocator (
  input  wire ooo_pkg::tag_t                       rob_tail,
  input  wire ooo_pkg::map_table_entry             map_table [`NUMBER_OF_REGISTERS],
  input  wire ooo_pkg::rob_entry                   rob [`ROB_SIZE],
  input  wire ooo_pkg::cdb_bus                     cdb_1,
  input  wire ooo_pkg::cdb_bus                     cdb_2,
  input  wire ooo_pkg::registers_dispatch_register regs_dis_reg,
  output ooo_pkg::map_table_entry                  mte,
  output ooo_pkg::rob_entry                        re,
  output ooo_pkg::rs_entry                         rse,
  output ooo_pkg::lsq_entry                        le,
  output logic                                     bypass_rs
);
  import ooo_pkg::*;

  control_bits ctrl;
  data_t val_1, val_2;
  tag_t tag_1, tag_2;
  data_t pc_plus4;

  // CDB first, then a ready ROB value, then the register file, else wait on the tag
  function automatic void resolve(input reg_idx_t src, input data_t rf_value,
                                  output data_t value, output tag_t tag);
    map_table_entry m;
    m = map_table[src];
    value = '0;
    tag = '0;
    if (m.tag != '0 && cdb_1.valid && cdb_1.tag == m.tag) begin
      value = cdb_1.value;
    end else if (m.tag != '0 && cdb_2.valid && cdb_2.tag == m.tag) begin
      value = cdb_2.value;
    end else if (m.tag != '0 && m.in_rob) begin
      value = rob[tag_slot(m.tag)].value;
    end else if (m.tag == '0) begin
      value = rf_value;
    end else begin
      tag = m.tag;
    end
  endfunction

  assign ctrl = regs_dis_reg.ctrl_bits;
  assign pc_plus4 = regs_dis_reg.pc + data_t'(4);

  // Operand selection with the per-opcode overrides
  always_comb begin
    resolve(regs_dis_reg.rs1, regs_dis_reg.rs1_value, val_1, tag_1);
    resolve(regs_dis_reg.rs2, regs_dis_reg.rs2_value, val_2, tag_2);
    // AUIPC takes the pc, LUI takes zero
    if (ctrl.apc) begin
      val_1 = (ctrl.opcode == OPC_AUIPC) ? regs_dis_reg.pc : '0;
      tag_1 = '0;
    end
    // I-type never waits on rs2, stores still need it
    if (ctrl.alusrc && !ctrl.memwr) begin
      val_2 = '0;
      tag_2 = '0;
    end
  end

  always_comb begin
    rse = '0;
    re = '0;
    mte = '0;
    bypass_rs = 1'b0;
    re.tag = rob_tail;
    re.ctrl_bits = ctrl;
    if (regs_dis_reg.valid) begin
      if (ctrl.ecall || ctrl.unsupported) begin
        // Nothing to execute, ROB entry is born ready
        bypass_rs = 1'b1;
        re.ready = 1'b1;
      end else if (ctrl.ucjump && !ctrl.alusrc) begin
        // JAL link value is known now
        bypass_rs = 1'b1;
        re.rd = regs_dis_reg.rd;
        re.value = pc_plus4;
        re.ready = 1'b1;
        mte.tag = rob_tail;
        mte.in_rob = 1'b1;
      end else begin
        rse.busy = 1'b1;
        rse.tag = rob_tail;
        rse.tag_1 = tag_1;
        rse.tag_2 = tag_2;
        rse.value_1 = val_1;
        rse.value_2 = val_2;
        rse.imm = regs_dis_reg.imm;
        rse.ctrl_bits = ctrl;
        re.rd = ctrl.regwrite ? regs_dis_reg.rd : '0;
        // JALR writes its link value, still waits for the target
        if (ctrl.ucjump) begin
          re.value = pc_plus4;
        end
        mte.tag = rob_tail;
        mte.in_rob = 1'b0;
      end
    end
  end

  // Load/store queue entry
  always_comb begin
    le = '0;
    if (regs_dis_reg.valid && (ctrl.memtoreg || ctrl.memwr)) begin
      le.category = ctrl.memwr ? LSQ_STORE : LSQ_LOAD;
      le.memory_type = ctrl.memory_type;
      le.tag = rob_tail;
    end
  end

endmodule

`default_nettype wire

/* dispatch_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defs.svh"

module dispatch_decode (
  input  wire logic                                clk,
  input  wire logic                                arst_n,
  input  wire logic                                instr_valid,
  input  wire logic [31:0]                         instr,
  input  wire ooo_pkg::data_t                      pc,
  input  wire ooo_pkg::rf_write_req                rf_write,
  output ooo_pkg::registers_dispatch_register      regs_dis_reg
);
  import ooo_pkg::*;

  data_t regfile [`NUMBER_OF_REGISTERS];

  registers_dispatch_register dec;
  registers_dispatch_register stage_q;
  logic valid_q;
  opcode_e opc;
  data_t imm_i, imm_s, imm_b, imm_u, imm_j;

  // Immediate formats
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign opc = opcode_e'(instr[6:0]);

  // x0 reads zero, a same-cycle commit write is forwarded
  function automatic data_t rf_read(input reg_idx_t idx);
    if (idx == '0) return '0;
    if (rf_write.valid && rf_write.rd == idx) return rf_write.value;
    return regfile[idx];
  endfunction

  always_comb begin
    dec = '0;
    dec.valid = instr_valid;
    dec.pc = pc;
    dec.instruction = instr;
    dec.rs1 = instr[19:15];
    dec.rs2 = instr[24:20];
    dec.rd = instr[11:7];
    dec.rs1_value = rf_read(instr[19:15]);
    dec.rs2_value = rf_read(instr[24:20]);
    dec.ctrl_bits.opcode = opc;
    dec.ctrl_bits.funct = {instr[30], instr[14:12]};
    case (opc)
      OPC_OP: dec.ctrl_bits.regwrite = 1'b1;
      OPC_OP_IMM: begin
        dec.ctrl_bits.alusrc = 1'b1;
        dec.ctrl_bits.regwrite = 1'b1;
        dec.imm = imm_i;
      end
      OPC_LOAD: begin
        dec.ctrl_bits.alusrc = 1'b1;
        dec.ctrl_bits.memtoreg = 1'b1;
        dec.ctrl_bits.regwrite = 1'b1;
        dec.ctrl_bits.memory_type = mem_type_e'(instr[14:12]);
        dec.imm = imm_i;
      end
      OPC_STORE: begin
        dec.ctrl_bits.alusrc = 1'b1;
        dec.ctrl_bits.memwr = 1'b1;
        dec.ctrl_bits.memory_type = mem_type_e'(instr[14:12]);
        dec.imm = imm_s;
      end
      OPC_BRANCH: begin
        dec.ctrl_bits.cjump = 1'b1;
        dec.imm = imm_b;
      end
      OPC_JAL: begin
        dec.ctrl_bits.ucjump = 1'b1;
        dec.ctrl_bits.regwrite = 1'b1;
        dec.imm = imm_j;
      end
      // JALR is told apart from JAL by alusrc
      OPC_JALR: begin
        dec.ctrl_bits.ucjump = 1'b1;
        dec.ctrl_bits.alusrc = 1'b1;
        dec.ctrl_bits.regwrite = 1'b1;
        dec.imm = imm_i;
      end
      OPC_LUI, OPC_AUIPC: begin
        dec.ctrl_bits.apc = 1'b1;
        dec.ctrl_bits.alusrc = 1'b1;
        dec.ctrl_bits.regwrite = 1'b1;
        dec.imm = imm_u;
      end
      OPC_SYSTEM: begin
        // Only a plain ECALL is supported
        dec.ctrl_bits.ecall = (instr[31:7] == '0);
        dec.ctrl_bits.unsupported = (instr[31:7] != '0);
        dec.imm = imm_i;
      end
      default: begin
        dec.ctrl_bits.opcode = OPC_ILLEGAL;
        dec.ctrl_bits.unsupported = 1'b1;
      end
    endcase
  end

  // Register file, cleared by reset, x0 never written
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `NUMBER_OF_REGISTERS; i++) begin
        regfile[i] <= '0;
      end
    end else if (rf_write.valid && rf_write.rd != '0) begin
      regfile[rf_write.rd] <= rf_write.value;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= instr_valid;
    end
  end

  // Decoded payload held until the next strobe
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      stage_q <= dec;
    end
  end

  always_comb begin
    regs_dis_reg = stage_q;
    regs_dis_reg.valid = valid_q;
  end

endmodule

`default_nettype wire

/* dispatch_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defs.svh"

module dispatch_top (
  input  wire logic                    clk,
  input  wire logic                    arst_n,
  input  wire logic                    instr_valid,
  input  wire logic [31:0]             instr,
  input  wire ooo_pkg::data_t          pc,
  input  wire ooo_pkg::cdb_bus         cdb_1,
  input  wire ooo_pkg::cdb_bus         cdb_2,
  input  wire ooo_pkg::commit_req      commit,
  output logic                         dispatch_valid,
  output ooo_pkg::rs_entry             rse,
  output ooo_pkg::rob_entry            rob_out,
  output ooo_pkg::lsq_entry            le,
  output logic                         bypass_rs
);
  import ooo_pkg::*;

  registers_dispatch_register regs_dis_reg;
  rf_write_req rf_write;
  tag_t rob_tail;
  map_table_entry map_table [`NUMBER_OF_REGISTERS];
  rob_entry rob [`ROB_SIZE];
  // Combinational entries from the allocator
  map_table_entry alloc_mte;
  rob_entry alloc_re;
  rs_entry alloc_rse;
  lsq_entry alloc_le;
  logic alloc_bypass;

  dispatch_decode u_decode (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .pc           (pc),
    .rf_write     (rf_write),
    .regs_dis_reg (regs_dis_reg)
  );

  allocator u_alloc (
    .rob_tail     (rob_tail),
    .map_table    (map_table),
    .rob          (rob),
    .cdb_1        (cdb_1),
    .cdb_2        (cdb_2),
    .regs_dis_reg (regs_dis_reg),
    .mte          (alloc_mte),
    .re           (alloc_re),
    .rse          (alloc_rse),
    .le           (alloc_le),
    .bypass_rs    (alloc_bypass)
  );

  rename_tracker u_tracker (
    .clk            (clk),
    .arst_n         (arst_n),
    .regs_dis_reg   (regs_dis_reg),
    .mte            (alloc_mte),
    .re             (alloc_re),
    .rse            (alloc_rse),
    .le             (alloc_le),
    .bypass_rs      (alloc_bypass),
    .cdb_1          (cdb_1),
    .cdb_2          (cdb_2),
    .commit         (commit),
    .rob_tail       (rob_tail),
    .map_table      (map_table),
    .rob            (rob),
    .rf_write       (rf_write),
    .dispatch_valid (dispatch_valid),
    .rse_out        (rse),
    .rob_out        (rob_out),
    .le_out         (le),
    .bypass_out     (bypass_rs)
  );

endmodule

`default_nettype wire

/* ooo_defs.svh */
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// Architectural register count
`define NUMBER_OF_REGISTERS 32

// Reorder buffer depth, tags run 1..ROB_SIZE
`define ROB_SIZE 8

// Reservation station count, sizes the rs_index field only
`define RS_SIZE 4

// Operand and result width
`define DATA_SIZE 32

// Tag width, wide enough for 0..ROB_SIZE
`define TAG_SIZE 4

`endif

/* ooo_pkg.sv */
`default_nettype none

`include "ooo_defs.svh"

package ooo_pkg;

  typedef logic [`DATA_SIZE-1:0] data_t;
  typedef logic [`TAG_SIZE-1:0] tag_t;
  typedef logic [$clog2(`NUMBER_OF_REGISTERS)-1:0] reg_idx_t;
  typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;
  typedef logic [$clog2(`RS_SIZE)-1:0] rs_idx_t;

  // Major opcodes, real RV32I encodings
  typedef enum logic [6:0] {
    OPC_OP      = 7'b0110011,
    OPC_OP_IMM  = 7'b0010011,
    OPC_LOAD    = 7'b0000011,
    OPC_STORE   = 7'b0100011,
    OPC_BRANCH  = 7'b1100011,
    OPC_JAL     = 7'b1101111,
    OPC_JALR    = 7'b1100111,
    OPC_LUI     = 7'b0110111,
    OPC_AUIPC   = 7'b0010111,
    OPC_SYSTEM  = 7'b1110011,
    OPC_ILLEGAL = 7'b0000000
  } opcode_e;

  // Access size and sign, same code as funct3
  typedef enum logic [2:0] {
    MEM_BYTE   = 3'b000,
    MEM_HALF   = 3'b001,
    MEM_WORD   = 3'b010,
    MEM_BYTE_U = 3'b100,
    MEM_HALF_U = 3'b101
  } mem_type_e;

  typedef enum logic [1:0] {
    LSQ_NONE  = 2'd0,
    LSQ_LOAD  = 2'd1,
    LSQ_STORE = 2'd2
  } lsq_category_e;

  typedef struct packed {
    opcode_e   opcode;
    logic      alusrc;
    logic      memwr;
    logic      memtoreg;
    logic      cjump;
    logic      ucjump;
    logic      apc;
    logic      ecall;
    logic      unsupported;
    logic      regwrite;
    mem_type_e memory_type;
    // funct7 bit 5 above funct3
    logic [3:0] funct;
  } control_bits;

  typedef struct packed {
    logic        valid;
    data_t       pc;
    logic [31:0] instruction;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    data_t       rs1_value;
    data_t       rs2_value;
    data_t       imm;
    control_bits ctrl_bits;
  } registers_dispatch_register;

  // in_rob set once the producer value sits ready in the ROB
  typedef struct packed {
    tag_t tag;
    logic in_rob;
  } map_table_entry;

  typedef struct packed {
    tag_t        tag;
    reg_idx_t    rd;
    data_t       value;
    logic        ready;
    control_bits ctrl_bits;
  } rob_entry;

  typedef struct packed {
    logic        busy;
    rs_idx_t     rs_index;
    tag_t        tag;
    tag_t        tag_1;
    tag_t        tag_2;
    data_t       value_1;
    data_t       value_2;
    data_t       imm;
    control_bits ctrl_bits;
  } rs_entry;

  typedef struct packed {
    lsq_category_e category;
    mem_type_e     memory_type;
    tag_t          tag;
  } lsq_entry;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    data_t value;
  } cdb_bus;

  typedef struct packed {
    logic valid;
    tag_t tag;
  } commit_req;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    data_t    value;
  } rf_write_req;

  // Tag 1..ROB_SIZE maps onto slot 0..ROB_SIZE-1
  function automatic rob_idx_t tag_slot(input tag_t tag);
    return rob_idx_t'(tag - tag_t'(1));
  endfunction

endpackage

`default_nettype wire

/* rename_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defs.svh"

module rename_tracker (
  input  wire logic                                clk,
  input  wire logic                                arst_n,
  input  wire ooo_pkg::registers_dispatch_register regs_dis_reg,
  input  wire ooo_pkg::map_table_entry             mte,
  input  wire ooo_pkg::rob_entry                   re,
  input  wire ooo_pkg::rs_entry                    rse,
  input  wire ooo_pkg::lsq_entry                   le,
  input  wire logic                                bypass_rs,
  input  wire ooo_pkg::cdb_bus                     cdb_1,
  input  wire ooo_pkg::cdb_bus                     cdb_2,
  input  wire ooo_pkg::commit_req                  commit,
  output ooo_pkg::tag_t                            rob_tail,
  output ooo_pkg::map_table_entry                  map_table [`NUMBER_OF_REGISTERS],
  output ooo_pkg::rob_entry                        rob [`ROB_SIZE],
  output ooo_pkg::rf_write_req                     rf_write,
  output logic                                     dispatch_valid,
  output ooo_pkg::rs_entry                         rse_out,
  output ooo_pkg::rob_entry                        rob_out,
  output ooo_pkg::lsq_entry                        le_out,
  output logic                                     bypass_out
);
  import ooo_pkg::*;

  logic writes_rd;

  // Tag 0 never matches a broadcast
  function automatic logic cdb_hit(input tag_t tag);
    return (tag != '0) && ((cdb_1.valid && cdb_1.tag == tag) ||
                           (cdb_2.valid && cdb_2.tag == tag));
  endfunction

  assign writes_rd = regs_dis_reg.valid && regs_dis_reg.ctrl_bits.regwrite &&
                     (regs_dis_reg.rd != '0);

  // Tail wraps ROB_SIZE back to 1
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rob_tail <= tag_t'(1);
    end else if (regs_dis_reg.valid) begin
      rob_tail <= (rob_tail == tag_t'(`ROB_SIZE)) ? tag_t'(1) : rob_tail + tag_t'(1);
    end
  end

  // Map table, a new rename overrides broadcast and commit on the same edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `NUMBER_OF_REGISTERS; i++) begin
        map_table[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `NUMBER_OF_REGISTERS; i++) begin
        if (cdb_hit(map_table[i].tag)) begin
          map_table[i].in_rob <= 1'b1;
        end
        if (commit.valid && commit.tag != '0 && map_table[i].tag == commit.tag) begin
          map_table[i] <= '0;
        end
      end
      if (writes_rd) begin
        map_table[regs_dis_reg.rd] <= mte;
      end
    end
  end

  // ROB storage
  always_ff @(posedge clk) begin
    if (cdb_1.valid && cdb_1.tag != '0) begin
      rob[tag_slot(cdb_1.tag)].value <= cdb_1.value;
      rob[tag_slot(cdb_1.tag)].ready <= 1'b1;
    end
    if (cdb_2.valid && cdb_2.tag != '0) begin
      rob[tag_slot(cdb_2.tag)].value <= cdb_2.value;
      rob[tag_slot(cdb_2.tag)].ready <= 1'b1;
    end
    // Freed slot stops looking ready
    if (commit.valid && commit.tag != '0) begin
      rob[tag_slot(commit.tag)].ready <= 1'b0;
    end
    if (regs_dis_reg.valid) begin
      rob[tag_slot(rob_tail)] <= re;
    end
  end

  // Commit write to the register file, only with a real destination
  always_comb begin
    rf_write = '0;
    if (commit.valid && commit.tag != '0) begin
      rf_write.rd = rob[tag_slot(commit.tag)].rd;
      rf_write.value = rob[tag_slot(commit.tag)].value;
      rf_write.valid = (rob[tag_slot(commit.tag)].rd != '0);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dispatch_valid <= 1'b0;
    end else begin
      dispatch_valid <= regs_dis_reg.valid;
    end
  end

  // Dispatch payload, meaningful with dispatch_valid
  always_ff @(posedge clk) begin
    if (regs_dis_reg.valid) begin
      rse_out <= rse;
      rob_out <= re;
      le_out <= le;
      bypass_out <= bypass_rs;
    end
  end

endmodule

`default_nettype wire

/* tb_dispatch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defs.svh"

module tb_dispatch;
  import ooo_pkg::*;

  localparam int NUM_TESTS = 6;
  localparam int CYCLES_PER_TEST = 200;
  localparam int CLK_PERIOD = 10;
  localparam cdb_bus NO_CDB = '0;

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  logic [31:0] instr;
  data_t       pc;
  cdb_bus      cdb_1;
  cdb_bus      cdb_2;
  commit_req   commit;
  logic        dispatch_valid;
  rs_entry     rse;
  rob_entry    rob_out;
  lsq_entry    le;
  logic        bypass_rs;

  integer seed;
  int errors;
  int checks;

  // Reference rename state
  tag_t     map_tag [`NUMBER_OF_REGISTERS];
  logic     map_ready [`NUMBER_OF_REGISTERS];
  data_t    rf_model [`NUMBER_OF_REGISTERS];
  data_t    rob_val [`ROB_SIZE];
  reg_idx_t rob_dest [`ROB_SIZE];
  tag_t     tail;

  dispatch_top uut (
    .clk            (clk),
    .arst_n         (arst_n),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .pc             (pc),
    .cdb_1          (cdb_1),
    .cdb_2          (cdb_2),
    .commit         (commit),
    .dispatch_valid (dispatch_valid),
    .rse            (rse),
    .rob_out        (rob_out),
    .le             (le),
    .bypass_rs      (bypass_rs)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog allows 200 cycles per test
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles",
             NUM_TESTS * CYCLES_PER_TEST);
    $display("Verification failed");
    $finish;
  end

  task automatic rs_compare(input string name, input rs_entry exp, input rs_entry act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic rob_compare(input string name, input rob_entry exp, input rob_entry act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic lsq_compare(input string name, input lsq_entry exp, input lsq_entry act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic flag_compare(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // Instruction encoders
  function automatic logic [31:0] r_word(input logic [6:0] f7, input reg_idx_t rs2,
                                         input reg_idx_t rs1, input logic [2:0] f3,
                                         input reg_idx_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input reg_idx_t rs1,
                                         input logic [2:0] f3, input reg_idx_t rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_word(input logic [11:0] imm, input reg_idx_t rs2,
                                         input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] u_word(input logic [19:0] imm, input reg_idx_t rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_word(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Expected control bits per opcode class
  function automatic control_bits decode_ctrl(input logic [31:0] word);
    control_bits c;
    c = '0;
    c.opcode = opcode_e'(word[6:0]);
    c.funct = {word[30], word[14:12]};
    case (word[6:0])
      OPC_OP: c.regwrite = 1'b1;
      OPC_OP_IMM: begin
        c.alusrc = 1'b1;
        c.regwrite = 1'b1;
      end
      OPC_LOAD: begin
        c.alusrc = 1'b1;
        c.memtoreg = 1'b1;
        c.regwrite = 1'b1;
        c.memory_type = mem_type_e'(word[14:12]);
      end
      OPC_STORE: begin
        c.alusrc = 1'b1;
        c.memwr = 1'b1;
        c.memory_type = mem_type_e'(word[14:12]);
      end
      OPC_BRANCH: c.cjump = 1'b1;
      OPC_JAL: begin
        c.ucjump = 1'b1;
        c.regwrite = 1'b1;
      end
      OPC_JALR: begin
        c.ucjump = 1'b1;
        c.alusrc = 1'b1;
        c.regwrite = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: begin
        c.apc = 1'b1;
        c.alusrc = 1'b1;
        c.regwrite = 1'b1;
      end
      OPC_SYSTEM: begin
        c.ecall = (word[31:7] == '0);
        c.unsupported = (word[31:7] != '0);
      end
      default: begin
        c.opcode = OPC_ILLEGAL;
        c.unsupported = 1'b1;
      end
    endcase
    return c;
  endfunction

  // Same-cycle broadcast, then ready ROB value, then register file, else wait
  function automatic void resolve_expected(input reg_idx_t src, input cdb_bus fwd,
                                           output data_t value, output tag_t tag);
    value = '0;
    tag = '0;
    if (map_tag[src] != '0 && fwd.valid && fwd.tag == map_tag[src]) begin
      value = fwd.value;
    end else if (map_tag[src] != '0 && map_ready[src]) begin
      value = rob_val[int'(map_tag[src]) - 1];
    end else if (map_tag[src] == '0) begin
      value = rf_model[src];
    end else begin
      tag = map_tag[src];
    end
  endfunction

  function automatic void apply_cdb(input cdb_bus c);
    if (c.valid && c.tag != '0) begin
      rob_val[int'(c.tag) - 1] = c.value;
      for (int i = 0; i < `NUMBER_OF_REGISTERS; i++) begin
        if (map_tag[i] == c.tag) begin
          map_ready[i] = 1'b1;
        end
      end
    end
  endfunction

  // Strobe one instruction with an optional broadcast during resolution and check outputs
  task automatic send_instr(input logic [31:0] word, input data_t addr, input data_t imm,
                            input cdb_bus fwd);
    control_bits ctrl;
    reg_idx_t rd;
    data_t v1;
    data_t v2;
    tag_t t1;
    tag_t t2;
    rs_entry exp_rs;
    rob_entry exp_rob;
    lsq_entry exp_lsq;
    logic exp_bypass;
    ctrl = decode_ctrl(word);
    rd = word[11:7];
    resolve_expected(word[19:15], fwd, v1, t1);
    resolve_expected(word[24:20], fwd, v2, t2);
    if (word[6:0] == OPC_AUIPC) begin
      v1 = addr;
      t1 = '0;
    end
    if (word[6:0] == OPC_LUI) begin
      v1 = '0;
      t1 = '0;
    end
    // I-type operand 2 is unused while stores keep it
    if (ctrl.alusrc && !ctrl.memwr) begin
      v2 = '0;
      t2 = '0;
    end
    exp_rs = '0;
    exp_rob = '0;
    exp_lsq = '0;
    exp_bypass = 1'b0;
    exp_rob.tag = tail;
    exp_rob.ctrl_bits = ctrl;
    if (ctrl.ecall || ctrl.unsupported) begin
      exp_bypass = 1'b1;
      exp_rob.ready = 1'b1;
    end else if (word[6:0] == OPC_JAL) begin
      exp_bypass = 1'b1;
      exp_rob.rd = rd;
      exp_rob.value = addr + 32'd4;
      exp_rob.ready = 1'b1;
    end else begin
      exp_rs.busy = 1'b1;
      exp_rs.tag = tail;
      exp_rs.tag_1 = t1;
      exp_rs.tag_2 = t2;
      exp_rs.value_1 = v1;
      exp_rs.value_2 = v2;
      exp_rs.imm = imm;
      exp_rs.ctrl_bits = ctrl;
      exp_rob.rd = ctrl.regwrite ? rd : '0;
      if (word[6:0] == OPC_JALR) begin
        exp_rob.value = addr + 32'd4;
      end
    end
    if (ctrl.memtoreg || ctrl.memwr) begin
      exp_lsq.category = ctrl.memwr ? LSQ_STORE : LSQ_LOAD;
      exp_lsq.memory_type = ctrl.memory_type;
      exp_lsq.tag = tail;
    end
    @(negedge clk);
    // Any earlier dispatch strobe has dropped by now
    flag_compare("dispatch_valid idle", 1'b0, dispatch_valid);
    instr_valid = 1'b1;
    instr = word;
    pc = addr;
    @(negedge clk);
    instr_valid = 1'b0;
    cdb_1 = fwd;
    // Two edges after the strobe
    @(negedge clk);
    cdb_1 = '0;
    flag_compare("dispatch_valid", 1'b1, dispatch_valid);
    rs_compare("rse", exp_rs, rse);
    rob_compare("rob_out", exp_rob, rob_out);
    lsq_compare("le", exp_lsq, le);
    flag_compare("bypass_rs", exp_bypass, bypass_rs);
    // Broadcast lands first and the new rename overrides it
    apply_cdb(fwd);
    if (ctrl.regwrite && rd != '0) begin
      map_tag[rd] = tail;
      map_ready[rd] = (word[6:0] == OPC_JAL);
    end
    rob_val[int'(tail) - 1] = exp_rob.value;
    rob_dest[int'(tail) - 1] = exp_rob.rd;
    tail = (tail == tag_t'(`ROB_SIZE)) ? tag_t'(1) : tail + tag_t'(1);
  endtask

  task automatic cdb_broadcast(input int bus, input tag_t tag, input data_t value);
    cdb_bus c;
    c.valid = 1'b1;
    c.tag = tag;
    c.value = value;
    @(negedge clk);
    if (bus == 1) begin
      cdb_1 = c;
    end else begin
      cdb_2 = c;
    end
    @(negedge clk);
    cdb_1 = '0;
    cdb_2 = '0;
    apply_cdb(c);
  endtask

  task automatic retire(input tag_t tag);
    int slot;
    @(negedge clk);
    commit.valid = 1'b1;
    commit.tag = tag;
    @(negedge clk);
    commit = '0;
    slot = int'(tag) - 1;
    if (rob_dest[slot] != '0) begin
      rf_model[rob_dest[slot]] = rob_val[slot];
    end
    for (int i = 0; i < `NUMBER_OF_REGISTERS; i++) begin
      if (map_tag[i] == tag) begin
        map_tag[i] = '0;
        map_ready[i] = 1'b0;
      end
    end
  endtask

  // x3 = x1 + x2 straight out of reset
  task automatic after_reset_add();
    flag_compare("dispatch_valid after reset", 1'b0, dispatch_valid);
    send_instr(r_word(7'b0, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP), 32'h100, '0, NO_CDB);
  endtask

  // x4 = x3 - 5 waits on the ADD tag
  task automatic dependent_addi();
    send_instr(i_word(12'hFFB, 5'd3, 3'b000, 5'd4, OPC_OP_IMM), 32'h104,
               32'hFFFF_FFFB, NO_CDB);
  endtask

  task automatic cdb_forwarding();
    cdb_bus fwd;
    fwd.valid = 1'b1;
    fwd.tag = tag_t'(1);
    fwd.value = $random(seed);
    // Tag 1 broadcast while x5 = x3 + x4 resolves
    send_instr(r_word(7'b0, 5'd4, 5'd3, 3'b000, 5'd5, OPC_OP), 32'h108, '0, fwd);
    // Tag 2 broadcast a cycle ahead and read back through the ROB
    cdb_broadcast(2, tag_t'(2), $random(seed));
    send_instr(r_word(7'b0, 5'd3, 5'd4, 3'b000, 5'd6, OPC_OP), 32'h10C, '0, NO_CDB);
  endtask

  task automatic commit_readback();
    retire(tag_t'(1));
    retire(tag_t'(2));
    send_instr(r_word(7'b0, 5'd4, 5'd3, 3'b000, 5'd7, OPC_OP), 32'h110, '0, NO_CDB);
  endtask

  task automatic bypass_and_jumps();
    send_instr(32'h0000_0073, 32'h114, '0, NO_CDB);
    send_instr(32'h0000_007F, 32'h118, '0, NO_CDB);
    send_instr(j_word(21'd16, 5'd1), 32'h11C, 32'd16, NO_CDB);
    // JALR reads the JAL link value already in the ROB
    send_instr(i_word(12'd8, 5'd1, 3'b000, 5'd2, OPC_JALR), 32'h120, 32'd8, NO_CDB);
  endtask

  task automatic memory_and_auipc();
    cdb_broadcast(1, tag_t'(3), $random(seed));
    cdb_broadcast(2, tag_t'(4), $random(seed));
    retire(tag_t'(3));
    retire(tag_t'(4));
    // Base x3 was committed and its old ROB slot now holds the JALR
    send_instr(i_word(12'd16, 5'd3, 3'b010, 5'd8, OPC_LOAD), 32'h124, 32'd16, NO_CDB);
    send_instr(s_word(12'd4, 5'd6, 5'd5, 3'b000), 32'h128, 32'd4, NO_CDB);
    send_instr(u_word(20'h12345, 5'd9, OPC_AUIPC), 32'h12C, 32'h1234_5000, NO_CDB);
  endtask

  initial begin
    seed = 77401;
    errors = 0;
    checks = 0;
    arst_n = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    pc = '0;
    cdb_1 = '0;
    cdb_2 = '0;
    commit = '0;
    tail = tag_t'(1);
    for (int i = 0; i < `NUMBER_OF_REGISTERS; i++) begin
      map_tag[i] = '0;
      map_ready[i] = 1'b0;
      rf_model[i] = '0;
    end
    for (int i = 0; i < `ROB_SIZE; i++) begin
      rob_val[i] = '0;
      rob_dest[i] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    after_reset_add();
    dependent_addi();
    cdb_forwarding();
    commit_readback();
    bypass_and_jumps();
    memory_and_auipc();
    repeat (2) @(negedge clk);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
ooo_pkg.sv
dispatch_decode.sv
allocator.sv
rename_tracker.sv
dispatch_top.sv
tb_dispatch.sv
